//--- cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cache geometry
`define CACHE_SETS 16
`define LINE_WORDS 4

// CPU and bus addresses count 32-bit words, not bytes
`define ADDR_BITS 32

// Derived field widths of a word address
`define SET_BITS $clog2(`CACHE_SETS)
`define OFFSET_BITS $clog2(`LINE_WORDS)

// Tag is whatever is left above set index and word offset
`define TAG_BITS (`ADDR_BITS - `SET_BITS - `OFFSET_BITS)

`endif

//--- cachePkg.sv
`default_nettype none
`include "cache_config.svh"

package cachePkg;

  typedef logic [`SET_BITS-1:0] setIndexT;
  typedef logic [`OFFSET_BITS-1:0] wordIndexT;

  // One load or store from the CPU
  typedef struct packed {
    logic                  write;
    logic [`ADDR_BITS-1:0] addr;
    logic [31:0]           wdata;
    logic [3:0]            mask;
  } cpuReqT;

  // Load data, or the stored word after merging for a store
  typedef struct packed {
    logic [31:0] rdata;
  } cpuRespT;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [`TAG_BITS-1:0] tag;
  } tagEntryT;

  // Whole cache line with word 0 in the low bits
  typedef logic [`LINE_WORDS-1:0][31:0] lineT;

  // Single-word transfer handed to the bus master
  typedef struct packed {
    logic                  write;
    logic [`ADDR_BITS-1:0] addr;
    logic [31:0]           wdata;
  } busReqT;

endpackage

`default_nettype wire

//--- axiPkg.sv
`default_nettype none

package axiPkg;

  // Unprivileged, secure, data access
  localparam logic [2:0] PROT_DATA = 3'b000;

  // AW and AR channels share one layout
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axiAddrT;

  // W channel
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axiWdataT;

  // R channel with a response code that goes unused
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axiRdataT;

endpackage

`default_nettype wire

//--- cpuRequestStage.sv
`default_nettype none

module cpuRequestStage
  import cachePkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset,
  input  wire logic   reqValid,
  output logic        reqReady,
  input  wire cpuReqT req,
  output logic        stageValid,
  output cpuReqT      stageReq,
  input  wire logic   take
);

  logic   full;
  cpuReqT held;

  // Room when empty, or when the held request leaves this cycle
  assign reqReady = !full || take;
  assign stageValid = full;
  assign stageReq = held;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full <= 1'b0;
    end else if (reqValid && reqReady) begin
      full <= 1'b1;
    end else if (take) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reqValid && reqReady) begin
      held <= req;
    end
  end

  // Controller sees one unchanging request until it takes it
  stageHoldsRequest: assert property (@(posedge clk) disable iff (reset)
    stageValid && !take |=> stageValid && $stable(stageReq));

endmodule

`default_nettype wire

//--- wayRam.sv
`default_nettype none
`include "cache_config.svh"

module wayRam
  import cachePkg::*;
#(
  parameter type entryT = tagEntryT
)
(
  input  wire logic     clk,
  input  wire setIndexT index,
  input  wire logic     writeEnable,
  input  wire entryT    writeEntry,
  output entryT        readEntry
);

  // One entry per set
  entryT mem [`CACHE_SETS];

  // Read is registered and returns the old entry on a write to the same set
  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[index] <= writeEntry;
    end
    readEntry <= mem[index];
  end

endmodule

`default_nettype wire

//--- cacheController.sv
`default_nettype none
`include "cache_config.svh"

module cacheController
  import cachePkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        stageValid,
  input  wire cpuReqT      stageReq,
  output logic             take,
  input  wire logic        flush,
  output logic             flushDone,
  output setIndexT         tagIndex,
  output logic             tagWrite0,
  output logic             tagWrite1,
  output tagEntryT         tagEntryOut,
  input  wire tagEntryT    tagEntry0,
  input  wire tagEntryT    tagEntry1,
  output logic             dataWrite0,
  output logic             dataWrite1,
  output lineT             lineOut,
  input  wire lineT        line0,
  input  wire lineT        line1,
  output logic             busReqValid,
  output busReqT           busReq,
  input  wire logic        busDone,
  input  wire logic [31:0] busRdata,
  output logic             respValid,
  output cpuRespT          resp
);

  typedef enum logic [2:0] {
    INIT, READY, LOOKUP, WRITEBACK, MEMREAD, FILL, FLUSH, FLUSHWB
  } stateT;

  localparam wordIndexT LAST_WORD = wordIndexT'(`LINE_WORDS - 1);

  stateT                state;
  cpuReqT               curReq;
  lineT                 lineBuf;
  logic [`TAG_BITS-1:0] victimTag;
  logic                 victimWay;
  logic [`CACHE_SETS-1:0] lruBits;
  // Set and way of the init and flush walks with the way in bit 0
  logic [`SET_BITS:0]   walkCnt;
  logic                 primed;
  wordIndexT            wordCnt;

  logic [`TAG_BITS-1:0] reqTag;
  setIndexT             reqSet;
  setIndexT             stageSet;
  setIndexT             walkSet;
  wordIndexT            reqWord;
  logic                 walkWay;
  logic                 walkLast;
  logic                 hit0;
  logic                 hit1;
  logic                 hit;
  logic                 hitWay;
  logic                 missWay;
  tagEntryT             victimEntry;
  tagEntryT             walkEntry;
  lineT                 hitLine;
  lineT                 walkLine;
  lineT                 mergedHit;
  lineT                 mergedFill;

  // Store bytes land in the addressed word, loads pass the line through
  function automatic lineT storeMerge(lineT line, cpuReqT r);
    lineT merged;
    merged = line;
    for (int b = 0; b < 4; b++) begin
      if (r.write && r.mask[b]) begin
        merged[r.addr[`OFFSET_BITS-1:0]][8*b +: 8] = r.wdata[8*b +: 8];
      end
    end
    return merged;
  endfunction

  assign reqTag = curReq.addr[`ADDR_BITS-1 -: `TAG_BITS];
  assign reqSet = curReq.addr[`OFFSET_BITS +: `SET_BITS];
  assign reqWord = curReq.addr[`OFFSET_BITS-1:0];
  assign stageSet = stageReq.addr[`OFFSET_BITS +: `SET_BITS];
  assign walkSet = walkCnt[`SET_BITS:1];
  assign walkWay = walkCnt[0];
  assign walkLast = &walkCnt;

  assign hit0 = tagEntry0.valid && (tagEntry0.tag == reqTag);
  assign hit1 = tagEntry1.valid && (tagEntry1.tag == reqTag);
  assign hit = hit0 || hit1;
  assign hitWay = hit1;
  assign hitLine = hitWay ? line1 : line0;

  // Empty way first, then the least recently used one
  assign missWay = !tagEntry0.valid ? 1'b0 : (!tagEntry1.valid ? 1'b1 : lruBits[reqSet]);
  assign victimEntry = missWay ? tagEntry1 : tagEntry0;
  assign walkEntry = walkWay ? tagEntry1 : tagEntry0;
  assign walkLine = walkWay ? line1 : line0;

  assign mergedHit = storeMerge(hitLine, curReq);
  assign mergedFill = storeMerge(lineBuf, curReq);

  assign take = (state == READY) && stageValid && !flush;

  always_comb begin
    tagIndex = reqSet;
    tagWrite0 = 1'b0;
    tagWrite1 = 1'b0;
    dataWrite0 = 1'b0;
    dataWrite1 = 1'b0;
    tagEntryOut = '0;
    lineOut = lineBuf;
    case (state)
      INIT: begin
        tagIndex = walkSet;
        tagWrite0 = !walkWay;
        tagWrite1 = walkWay;
      end
      READY: tagIndex = stageSet;
      LOOKUP: begin
        if (hit && curReq.write) begin
          tagWrite0 = !hitWay;
          tagWrite1 = hitWay;
          dataWrite0 = !hitWay;
          dataWrite1 = hitWay;
          tagEntryOut = '{valid: 1'b1, dirty: 1'b1, tag: reqTag};
          lineOut = mergedHit;
        end
      end
      FILL: begin
        tagWrite0 = !victimWay;
        tagWrite1 = victimWay;
        dataWrite0 = !victimWay;
        dataWrite1 = victimWay;
        tagEntryOut = '{valid: 1'b1, dirty: curReq.write, tag: reqTag};
        lineOut = mergedFill;
      end
      FLUSH: tagIndex = walkSet;
      FLUSHWB: begin
        tagIndex = walkSet;
        // Line is clean once its last word is in memory
        if (busDone && wordCnt == LAST_WORD) begin
          tagWrite0 = !walkWay;
          tagWrite1 = walkWay;
          tagEntryOut = '{valid: 1'b1, dirty: 1'b0, tag: victimTag};
        end
      end
      default: ;
    endcase
  end

  assign busReqValid = (state == WRITEBACK) || (state == MEMREAD) || (state == FLUSHWB);
  assign busReq.write = (state != MEMREAD);
  assign busReq.addr = {(state == MEMREAD) ? reqTag : victimTag, tagIndex, wordCnt};
  assign busReq.wdata = lineBuf[wordCnt];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= INIT;
      walkCnt <= '0;
      wordCnt <= '0;
      primed <= 1'b0;
      lruBits <= '0;
      respValid <= 1'b0;
      flushDone <= 1'b0;
    end else begin
      respValid <= 1'b0;
      flushDone <= 1'b0;
      case (state)
        INIT: begin
          walkCnt <= walkCnt + 1'b1;
          if (walkLast) state <= READY;
        end
        READY: begin
          if (flush) begin
            primed <= 1'b0;
            state <= FLUSH;
          end else if (stageValid) begin
            state <= LOOKUP;
          end
        end
        LOOKUP: begin
          wordCnt <= '0;
          if (hit) begin
            respValid <= 1'b1;
            lruBits[reqSet] <= !hitWay;
            state <= READY;
          end else if (victimEntry.valid && victimEntry.dirty) begin
            state <= WRITEBACK;
          end else begin
            state <= MEMREAD;
          end
        end
        WRITEBACK: begin
          if (busDone) begin
            wordCnt <= wordCnt + 1'b1;
            if (wordCnt == LAST_WORD) state <= MEMREAD;
          end
        end
        MEMREAD: begin
          if (busDone) begin
            wordCnt <= wordCnt + 1'b1;
            if (wordCnt == LAST_WORD) state <= FILL;
          end
        end
        FILL: begin
          respValid <= 1'b1;
          lruBits[reqSet] <= !victimWay;
          state <= READY;
        end
        FLUSH: begin
          // Tag RAM output lags the walk index by one cycle
          if (!primed) begin
            primed <= 1'b1;
          end else if (walkEntry.valid && walkEntry.dirty) begin
            wordCnt <= '0;
            state <= FLUSHWB;
          end else begin
            walkCnt <= walkCnt + 1'b1;
            if (walkWay) primed <= 1'b0;
            if (walkLast) begin
              flushDone <= 1'b1;
              state <= READY;
            end
          end
        end
        FLUSHWB: begin
          if (busDone) begin
            wordCnt <= wordCnt + 1'b1;
            if (wordCnt == LAST_WORD) begin
              primed <= 1'b0;
              state <= FLUSH;
            end
          end
        end
        default: state <= READY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) curReq <= stageReq;
    if (state == LOOKUP) begin
      lineBuf <= missWay ? line1 : line0;
      victimTag <= victimEntry.tag;
      victimWay <= missWay;
      resp.rdata <= mergedHit[reqWord];
    end
    if (state == FLUSH && primed) begin
      lineBuf <= walkLine;
      victimTag <= walkEntry.tag;
    end
    if (state == MEMREAD && busDone) lineBuf[wordCnt] <= busRdata;
    if (state == FILL) resp.rdata <= mergedFill[reqWord];
  end

  // Bus master relies on a steady request until it finishes
  busRequestHeld: assert property (@(posedge clk) disable iff (reset)
    busReqValid && !busDone |=> busReqValid && $stable(busReq));

  // A tag never sits in both ways of one set
  singleWayHit: assert property (@(posedge clk) disable iff (reset)
    state == LOOKUP |-> !(hit0 && hit1));

endmodule

`default_nettype wire

//--- axiLiteMaster.sv
`default_nettype none
`include "cache_config.svh"

module axiLiteMaster
  import cachePkg::*;
  import axiPkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire logic        busReqValid,
  input  wire busReqT      busReq,
  output logic             busDone,
  output logic [31:0]      busRdata,
  output logic             awValid,
  output axiAddrT          aw,
  input  wire logic        awReady,
  output logic             wValid,
  output axiWdataT         w,
  input  wire logic        wReady,
  input  wire logic        bValid,
  output logic             bReady,
  output logic             arValid,
  output axiAddrT          ar,
  input  wire logic        arReady,
  input  wire logic        rValid,
  input  wire axiRdataT    r,
  output logic             rReady
);

  typedef enum logic [1:0] {IDLE, WRITE, READ} stateT;

  stateT   state;
  axiAddrT byteAddr;

  // Word address to AXI byte address; the controller holds busReq steady
  assign byteAddr.addr = {busReq.addr[`ADDR_BITS-3:0], 2'b00};
  assign byteAddr.prot = PROT_DATA;
  assign aw = byteAddr;
  assign ar = byteAddr;
  assign w.data = busReq.wdata;
  // Stores are merged into the line, so every write is a full word
  assign w.strb = 4'hf;

  // Response is taken only after the request side has fully gone out
  assign bReady = (state == WRITE) && !awValid && !wValid;
  assign rReady = (state == READ) && !arValid;
  assign busDone = (bValid && bReady) || (rValid && rReady);
  assign busRdata = r.data;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= IDLE;
      awValid <= 1'b0;
      wValid <= 1'b0;
      arValid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (busReqValid && busReq.write) begin
            awValid <= 1'b1;
            wValid <= 1'b1;
            state <= WRITE;
          end else if (busReqValid) begin
            arValid <= 1'b1;
            state <= READ;
          end
        end
        WRITE: begin
          // AW and W complete independently
          if (awReady) awValid <= 1'b0;
          if (wReady) wValid <= 1'b0;
          if (bValid && bReady) state <= IDLE;
        end
        READ: begin
          if (arReady) arValid <= 1'b0;
          if (rValid && rReady) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  awValidHeld: assert property (@(posedge clk) disable iff (reset)
    awValid && !awReady |=> awValid);

endmodule

`default_nettype wire

//--- dataCache.sv
`default_nettype none

module dataCache
  import cachePkg::*;
  import axiPkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     reqValid,
  output logic          reqReady,
  input  wire cpuReqT   req,
  output logic          respValid,
  output cpuRespT       resp,
  input  wire logic     flush,
  output logic          flushDone,
  output logic          awValid,
  output axiAddrT       aw,
  input  wire logic     awReady,
  output logic          wValid,
  output axiWdataT      w,
  input  wire logic     wReady,
  input  wire logic     bValid,
  output logic          bReady,
  output logic          arValid,
  output axiAddrT       ar,
  input  wire logic     arReady,
  input  wire logic     rValid,
  input  wire axiRdataT r,
  output logic          rReady
);

  logic        stageValid;
  cpuReqT      stageReq;
  logic        take;
  setIndexT    tagIndex;
  logic        tagWrite0;
  logic        tagWrite1;
  tagEntryT    tagEntryOut;
  tagEntryT    tagEntry0;
  tagEntryT    tagEntry1;
  logic        dataWrite0;
  logic        dataWrite1;
  lineT        lineOut;
  lineT        line0;
  lineT        line1;
  logic        busReqValid;
  busReqT      busReq;
  logic        busDone;
  logic [31:0] busRdata;

  cpuRequestStage requestStage (
    .clk(clk), .reset(reset), .reqValid(reqValid), .reqReady(reqReady), .req(req),
    .stageValid(stageValid), .stageReq(stageReq), .take(take)
  );

  // Tag and data arrays of the two ways share one set index
  wayRam #(.entryT(tagEntryT)) tagWay0 (
    .clk(clk), .index(tagIndex), .writeEnable(tagWrite0),
    .writeEntry(tagEntryOut), .readEntry(tagEntry0)
  );
  wayRam #(.entryT(tagEntryT)) tagWay1 (
    .clk(clk), .index(tagIndex), .writeEnable(tagWrite1),
    .writeEntry(tagEntryOut), .readEntry(tagEntry1)
  );
  wayRam #(.entryT(lineT)) dataWay0 (
    .clk(clk), .index(tagIndex), .writeEnable(dataWrite0),
    .writeEntry(lineOut), .readEntry(line0)
  );
  wayRam #(.entryT(lineT)) dataWay1 (
    .clk(clk), .index(tagIndex), .writeEnable(dataWrite1),
    .writeEntry(lineOut), .readEntry(line1)
  );

  cacheController controller (
    .clk(clk), .reset(reset), .stageValid(stageValid), .stageReq(stageReq), .take(take),
    .flush(flush), .flushDone(flushDone), .tagIndex(tagIndex),
    .tagWrite0(tagWrite0), .tagWrite1(tagWrite1), .tagEntryOut(tagEntryOut),
    .tagEntry0(tagEntry0), .tagEntry1(tagEntry1),
    .dataWrite0(dataWrite0), .dataWrite1(dataWrite1), .lineOut(lineOut),
    .line0(line0), .line1(line1), .busReqValid(busReqValid), .busReq(busReq),
    .busDone(busDone), .busRdata(busRdata), .respValid(respValid), .resp(resp)
  );

  axiLiteMaster busMaster (
    .clk(clk), .reset(reset), .busReqValid(busReqValid), .busReq(busReq),
    .busDone(busDone), .busRdata(busRdata),
    .awValid(awValid), .aw(aw), .awReady(awReady),
    .wValid(wValid), .w(w), .wReady(wReady),
    .bValid(bValid), .bReady(bReady),
    .arValid(arValid), .ar(ar), .arReady(arReady),
    .rValid(rValid), .r(r), .rReady(rReady)
  );

endmodule

`default_nettype wire

//--- tbMemory.sv
`default_nettype none

module tbMemory
  import axiPkg::*;
#(
  parameter logic [31:0] SEED = 32'h1,
  parameter logic [31:0] PATTERN = 32'h0
)
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     awValid,
  input  wire axiAddrT  aw,
  output logic          awReady,
  input  wire logic     wValid,
  input  wire axiWdataT w,
  output logic          wReady,
  output logic          bValid,
  input  wire logic     bReady,
  input  wire logic     arValid,
  input  wire axiAddrT  ar,
  output logic          arReady,
  output logic          rValid,
  output axiRdataT      r,
  input  wire logic     rReady
);

  localparam int WORDS = 256;

  // Backing store, one entry per 32-bit word
  logic [31:0] mem [WORDS];
  integer      seed;
  logic [31:0] roll;
  logic        haveAw;
  logic        haveW;
  logic        readPending;
  logic [7:0]  writeIndex;
  logic [7:0]  readIndex;
  logic [31:0] writeData;

  initial begin
    seed = SEED;
    for (int i = 0; i < WORDS; i++) begin
      mem[8'(i)] = 32'(i) ^ PATTERN;
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      awReady <= 1'b0;
      wReady <= 1'b0;
      arReady <= 1'b0;
      bValid <= 1'b0;
      rValid <= 1'b0;
      r <= '0;
      haveAw <= 1'b0;
      haveW <= 1'b0;
      readPending <= 1'b0;
      writeIndex <= '0;
      readIndex <= '0;
      writeData <= '0;
    end else begin
      // One draw per cycle sets every ready and response delay
      roll = $random(seed);
      awReady <= !haveAw && (roll[1:0] != 2'b00);
      wReady <= !haveW && (roll[3:2] != 2'b00);
      arReady <= !readPending && !rValid && (roll[5:4] != 2'b00);

      // Write lands in the array once both AW and W are in
      if (haveAw && haveW && !bValid && roll[6]) begin
        mem[writeIndex] = writeData;
        bValid <= 1'b1;
        haveAw <= 1'b0;
        haveW <= 1'b0;
      end
      if (bValid && bReady) bValid <= 1'b0;
      if (awValid && awReady) begin
        haveAw <= 1'b1;
        writeIndex <= aw.addr[9:2];
      end
      if (wValid && wReady) begin
        haveW <= 1'b1;
        writeData <= w.data;
      end

      if (readPending && !rValid && roll[7]) begin
        rValid <= 1'b1;
        r <= '{data: mem[readIndex], resp: 2'b00};
        readPending <= 1'b0;
      end
      if (rValid && rReady) rValid <= 1'b0;
      if (arValid && arReady) begin
        readPending <= 1'b1;
        readIndex <= ar.addr[9:2];
      end
    end
  end

endmodule

`default_nettype wire

//--- dataCacheTb.sv
`default_nettype none

module dataCacheTb
  import cachePkg::*;
  import axiPkg::*;
();

  localparam int HALF_PERIOD = 20;
  localparam logic [31:0] SEED = 32'ha82d_83fd;
  localparam logic [31:0] PATTERN = 32'h3c96_0000;
  localparam int MEM_WORDS = 256;
  localparam int REQ_LIMIT = 500;
  localparam int DRAIN_LIMIT = 5000;
  localparam int FLUSH_LIMIT = 20000;

  logic clk;
  logic reset;
  logic reqValid;
  logic reqReady;
  cpuReqT req;
  logic respValid;
  cpuRespT resp;
  logic flush;
  logic flushDone;
  logic awValid;
  logic awReady;
  logic wValid;
  logic wReady;
  logic bValid;
  logic bReady;
  logic arValid;
  logic arReady;
  logic rValid;
  logic rReady;
  axiAddrT aw;
  axiAddrT ar;
  axiWdataT w;
  axiRdataT r;

  integer seed;
  int errors;
  int timeouts;
  logic [31:0] shadow [MEM_WORDS];
  logic [31:0] expected [$];

  dataCache i_dut (
    .clk(clk), .reset(reset), .reqValid(reqValid), .reqReady(reqReady), .req(req),
    .respValid(respValid), .resp(resp), .flush(flush), .flushDone(flushDone),
    .awValid(awValid), .aw(aw), .awReady(awReady), .wValid(wValid), .w(w),
    .wReady(wReady), .bValid(bValid), .bReady(bReady), .arValid(arValid), .ar(ar),
    .arReady(arReady), .rValid(rValid), .r(r), .rReady(rReady)
  );

  tbMemory #(.SEED(SEED), .PATTERN(PATTERN)) memory (
    .clk(clk), .reset(reset), .awValid(awValid), .aw(aw), .awReady(awReady),
    .wValid(wValid), .w(w), .wReady(wReady), .bValid(bValid), .bReady(bReady),
    .arValid(arValid), .ar(ar), .arReady(arReady), .rValid(rValid), .r(r),
    .rReady(rReady)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // Load returns the shadow word, store merges its bytes and returns the result
  function automatic logic [31:0] refAccess(input cpuReqT op);
    logic [31:0] word;
    word = shadow[op.addr[7:0]];
    if (op.write) begin
      for (int b = 0; b < 4; b++) begin
        if (op.mask[b]) word[8*b +: 8] = op.wdata[8*b +: 8];
      end
      shadow[op.addr[7:0]] = word;
    end
    return word;
  endfunction

  function automatic cpuReqT makeRequest(input logic write, input logic [31:0] addr,
                                         input logic [31:0] data, input logic [3:0] mask);
    cpuReqT op;
    op.write = write;
    op.addr = addr;
    op.wdata = data;
    op.mask = mask;
    return op;
  endfunction

  function automatic cpuReqT randomRequest();
    logic [31:0] rnd;
    logic [31:0] data;
    rnd = $random(seed);
    data = $random(seed);
    return makeRequest(rnd[8], {24'd0, rnd[7:0]}, data, rnd[12:9]);
  endfunction

  // Response checker sampled mid-cycle
  always @(negedge clk) begin
    if (respValid) begin
      if (expected.size() == 0) begin
        $display("Got a response of 0x%08h with no request outstanding", resp.rdata);
        errors++;
      end else begin
        if (resp.rdata !== expected[0]) begin
          $display("FAIL %0t: response 0x%08h, expected 0x%08h",
                   $time, resp.rdata, expected[0]);
          errors++;
        end
        void'(expected.pop_front());
      end
    end
  end

  // Line traffic is whole words of plain data access
  always @(negedge clk) begin
    if (awValid && aw.prot !== 3'b000) begin
      $display("FAIL %0t: AW prot 0x%0h, expected 0x0", $time, aw.prot);
      errors++;
    end
    if (arValid && ar.prot !== 3'b000) begin
      $display("FAIL %0t: AR prot 0x%0h, expected 0x0", $time, ar.prot);
      errors++;
    end
    if (wValid && w.strb !== 4'hf) begin
      $display("FAIL %0t: WSTRB 0x%0h, expected 0xf", $time, w.strb);
      errors++;
    end
  end

  // Called on a falling edge; leaves reqValid high for back-to-back use
  task automatic sendRequest(input cpuReqT op);
    int waited;
    waited = 0;
    req = op;
    reqValid = 1'b1;
    while (!reqReady && waited < REQ_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (reqReady) begin
      expected.push_back(refAccess(op));
    end else begin
      $display("Timed out waiting for the cache to accept address 0x%08h", op.addr);
      timeouts++;
      reqValid = 1'b0;
    end
    @(negedge clk);
  endtask

  task automatic drainResponses();
    int waited;
    waited = 0;
    reqValid = 1'b0;
    while (expected.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("Timed out with %0d responses still missing", expected.size());
      timeouts++;
      expected.delete();
    end
  endtask

  task automatic checkWord(input int index);
    if (memory.mem[8'(index)] !== shadow[8'(index)]) begin
      $display("FAIL %0t: memory word 0x%02h holds 0x%08h, expected 0x%08h",
               $time, index, memory.mem[8'(index)], shadow[8'(index)]);
      errors++;
    end
  endtask

  initial begin
    int waited;
    logic [31:0] gap;
    seed = SEED;
    errors = 0;
    timeouts = 0;
    reset = 1'b1;
    reqValid = 1'b0;
    req = '0;
    flush = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[8'(i)] = 32'(i) ^ PATTERN;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Cold reads in sets 0, 5, 10 and 15
    sendRequest(makeRequest(1'b0, 32'h00, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b0, 32'h15, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b0, 32'h2a, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b0, 32'h3f, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b0, 32'h83, 32'h0, 4'h0));
    drainResponses();

    // Masked store miss then hit in set 9
    sendRequest(makeRequest(1'b1, 32'h24, 32'hdead_beef, 4'b0101));
    sendRequest(makeRequest(1'b0, 32'h24, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b1, 32'h25, 32'h0bad_cafe, 4'b1000));
    sendRequest(makeRequest(1'b0, 32'h25, 32'h0, 4'h0));
    drainResponses();

    // Three tags in set 7 evict the dirty line at 0x1c
    sendRequest(makeRequest(1'b1, 32'h1c, 32'h1234_5678, 4'b1111));
    sendRequest(makeRequest(1'b0, 32'h5c, 32'h0, 4'h0));
    sendRequest(makeRequest(1'b0, 32'h9c, 32'h0, 4'h0));
    drainResponses();
    checkWord(32'h1c);
    sendRequest(makeRequest(1'b0, 32'h1c, 32'h0, 4'h0));
    drainResponses();

    // Back-to-back traffic
    for (int n = 0; n < 40; n++) begin
      sendRequest(randomRequest());
    end
    drainResponses();

    // Random mix with idle gaps
    for (int n = 0; n < 300; n++) begin
      sendRequest(randomRequest());
      gap = $random(seed);
      if (gap[0]) begin
        reqValid = 1'b0;
        @(negedge clk);
      end
    end
    drainResponses();

    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    waited = 0;
    while (!flushDone && waited < FLUSH_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (flushDone) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        checkWord(i);
      end
    end else begin
      $display("Timed out waiting for the flush to complete");
      timeouts++;
    end

    $display("Finished with %0d wrong values and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
cachePkg.sv
axiPkg.sv
cpuRequestStage.sv
wayRam.sv
cacheController.sv
axiLiteMaster.sv
dataCache.sv
tbMemory.sv
dataCacheTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module dataCacheTb -o dataCacheSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/dataCacheSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" sim.log; then
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
